// File: src/rst_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the clock and reset controller.
// Referenced from the RTL and the testbench by scoped names.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rst_pkg;

   // interval counters, wide enough for ms prescaler and systick
   typedef logic [15:0] cnt_t;

   // button conditioner status towards the sequencer
   typedef struct packed {
      logic key_down;            // debounced press, or pll fault pending
      logic pwr_req;             // pll unlocked or long press
      logic pll_ok;              // synchronized lock
   } key_stat_t;

   // reset lines, all active high
   typedef struct packed {
      logic pwr_rst;             // power reset
      logic sys_rst;             // warm system reset
      logic dclo;                // dc low, released after sys_rst
      logic aclo;                // ac low, released last
   } rst_lines_t;

   // timebase outputs
   typedef struct packed {
      logic us;                  // 1 us enable pulse
      logic ms;                  // 1 ms enable pulse
      logic slow;                // slow clock enable
      logic irq;                 // system timer square wave
   } strobes_t;

   // reset sequencer states
   typedef enum logic [2:0] {
      st_power,                  // power reset held
      st_wait_ready,             // wait for sys_ready and button release
      st_dclo,                   // dclo width
      st_aclo,                   // aclo delay
      st_run                     // all lines released
   } seq_state_t;

endpackage : rst_pkg

`default_nettype wire

// File: src/rst_button_cond.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset button and PLL lock conditioning.
// Synchronizes both pins, debounces the button on a local millisecond
// tick and flags long presses or lock loss as a power request.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rst_button_cond #(
   parameter int osc_per_ms  = 50000,  // osc_clk cycles per millisecond
   parameter int debounce_ms = 10,     // quiet time before release
   parameter int longkey_ms  = 1000    // hold time for a power request
) (
   input  logic               osc_clk,
   input  logic               pwr_event,  // async, active high
   input  logic               button_n,   // raw button, low when pressed
   input  logic               pll_lock,   // raw lock status
   output rst_pkg::key_stat_t key
);

   logic [1:0]    btn_sync;      // button synchronizer
   logic [1:0]    pll_sync;      // lock synchronizer
   logic          btn_ok;        // button released, synchronized
   logic          pll_ok;        // lock present, synchronized

   rst_pkg::cnt_t ms_cnt;        // millisecond prescaler
   logic          ms_tick;       // one cycle per millisecond
   rst_pkg::cnt_t db_cnt;        // quiet milliseconds so far
   rst_pkg::cnt_t kl_cnt;        // held milliseconds so far
   logic          key_down;
   logic          key_long;
   logic          pwr_req;

   // two flop synchronizers, cleared state looks like pressed and unlocked
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         btn_sync <= '0;
         pll_sync <= '0;
      end
      else
      begin
         btn_sync <= {btn_sync[0], button_n};
         pll_sync <= {pll_sync[0], pll_lock};
      end
   end

   assign btn_ok = btn_sync[1];
   assign pll_ok = pll_sync[1];

   // free running ms tick, phase not tied to the button
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         ms_cnt  <= '0;
         ms_tick <= 1'b0;
      end
      else if (ms_cnt == rst_pkg::cnt_t'(osc_per_ms - 1))
      begin
         ms_cnt  <= '0;
         ms_tick <= 1'b1;
      end
      else
      begin
         ms_cnt  <= ms_cnt + 1'b1;
         ms_tick <= 1'b0;
      end
   end

   // debouncer
   // any press or unlock restarts the quiet interval
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         db_cnt   <= '0;
         key_down <= 1'b1;
      end
      else if (!btn_ok || !pll_ok)
      begin
         db_cnt   <= '0;
         key_down <= 1'b1;
      end
      else if (ms_tick)
      begin
         if (db_cnt < rst_pkg::cnt_t'(debounce_ms))
            db_cnt <= db_cnt + 1'b1;  // partial first tick not counted as quiet
         else
            key_down <= 1'b0;
      end
   end

   // long press detector, only runs while key_down is held
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         kl_cnt   <= '0;
         key_long <= 1'b0;
      end
      else if (!key_down)
      begin
         kl_cnt   <= '0;
         key_long <= 1'b0;
      end
      else if (ms_tick)
      begin
         if (kl_cnt < rst_pkg::cnt_t'(longkey_ms - 1))
            kl_cnt <= kl_cnt + 1'b1;
         else
            key_long <= 1'b1;                 // held long enough
      end
   end

   // power request, registered
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
         pwr_req <= 1'b1;
      else
         pwr_req <= !pll_ok || key_long;
   end

   assign key = '{key_down: key_down, pwr_req: pwr_req, pll_ok: pll_ok};

endmodule : rst_button_cond

`default_nettype wire

// File: src/rst_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset sequencer.
// Holds power reset for a minimum width, waits for sys_ready, then
// releases sys_rst, DCLO and ACLO in that order. A press restarts
// the warm part of the sequence, a power request restarts all of it.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rst_sequencer #(
   parameter int pwr_width  = 7,    // min power reset width, cycles
   parameter int dclo_width = 15,   // min dclo width after sys_rst, cycles
   parameter int aclo_delay = 7     // aclo release after dclo, cycles
) (
   input  logic                osc_clk,
   input  logic                pwr_event,   // async, active high
   input  rst_pkg::key_stat_t  key,         // from button conditioner
   input  logic                sys_ready,   // system may leave reset
   output rst_pkg::rst_lines_t lines
);

   rst_pkg::seq_state_t state;
   rst_pkg::cnt_t       cnt;        // width and delay counter

   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         state <= rst_pkg::st_power;
         cnt   <= '0;
         lines <= '1;                        // everything held
      end
      else if (key.pwr_req)
      begin
         // power request wins from any state
         state <= rst_pkg::st_power;
         cnt   <= '0;
         lines <= '1;
      end
      else
      begin
         case (state)
            rst_pkg::st_power:
            begin
               if (cnt < rst_pkg::cnt_t'(pwr_width - 1))
                  cnt <= cnt + 1'b1;
               else
               begin
                  cnt           <= '0;
                  lines.pwr_rst <= 1'b0;
                  state         <= rst_pkg::st_wait_ready;
               end
            end

            rst_pkg::st_wait_ready:
            begin
               // memory controller etc may still be initializing
               if (sys_ready && !key.key_down)
               begin
                  cnt           <= '0;
                  lines.sys_rst <= 1'b0;
                  state         <= rst_pkg::st_dclo;
               end
            end

            rst_pkg::st_dclo, rst_pkg::st_aclo, rst_pkg::st_run:
            begin
               if (key.key_down)
               begin
                  // warm reset, pwr_rst left alone
                  cnt           <= '0;
                  lines.sys_rst <= 1'b1;
                  lines.dclo    <= 1'b1;
                  lines.aclo    <= 1'b1;
                  state         <= rst_pkg::st_wait_ready;
               end
               else if (state == rst_pkg::st_dclo)
               begin
                  if (cnt < rst_pkg::cnt_t'(dclo_width - 1))
                     cnt <= cnt + 1'b1;
                  else
                  begin
                     cnt        <= '0;
                     lines.dclo <= 1'b0;
                     state      <= rst_pkg::st_aclo;
                  end
               end
               else if (state == rst_pkg::st_aclo)
               begin
                  if (cnt < rst_pkg::cnt_t'(aclo_delay - 1))
                     cnt <= cnt + 1'b1;
                  else
                  begin
                     cnt        <= '0;
                     lines.aclo <= 1'b0;  // fully out of reset
                     state      <= rst_pkg::st_run;
                  end
               end
            end

            default:
            begin
               state <= rst_pkg::st_power;
               cnt   <= '0;
               lines <= '1;
            end
         endcase
      end
   end

endmodule : rst_sequencer

`default_nettype wire

// File: src/rst_timebase.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System timebase.
// Produces 1 us, 1 ms and slow enable pulses plus the systick
// interrupt level. Everything restarts from zero while sys_rst is high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rst_timebase #(
   parameter int clk_per_us = 50,     // cycles per microsecond
   parameter int systick_us = 20000,  // timer interrupt period in us
   parameter int slow_div   = 20      // slow strobe divisor
) (
   input  logic              osc_clk,
   input  logic              pwr_event,  // async, active high
   input  logic              sys_rst,    // sync clear of the whole timebase
   output rst_pkg::strobes_t strobes
);

   rst_pkg::cnt_t cyc_cnt;       // cycles within a us
   rst_pkg::cnt_t us_cnt;        // us within a ms
   rst_pkg::cnt_t st_cnt;        // us within a systick period
   rst_pkg::cnt_t sl_cnt;        // slow divider
   logic          ena_us;        // us wrap, strobes.us follows one cycle later

   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         cyc_cnt <= '0;
         us_cnt  <= '0;
         st_cnt  <= '0;
         sl_cnt  <= '0;
         ena_us  <= 1'b0;
         strobes <= '0;
      end
      else if (sys_rst)
      begin
         cyc_cnt <= '0;
         us_cnt  <= '0;
         st_cnt  <= '0;
         sl_cnt  <= '0;
         ena_us  <= 1'b0;
         strobes <= '0;
      end
      else
      begin
         // slow divider
         if (sl_cnt == rst_pkg::cnt_t'(slow_div - 1))
         begin
            sl_cnt       <= '0;
            strobes.slow <= 1'b1;
         end
         else
         begin
            sl_cnt       <= sl_cnt + 1'b1;
            strobes.slow <= 1'b0;
         end

         // microsecond prescaler
         if (cyc_cnt == rst_pkg::cnt_t'(clk_per_us - 1))
         begin
            cyc_cnt <= '0;
            ena_us  <= 1'b1;
         end
         else
         begin
            cyc_cnt <= cyc_cnt + 1'b1;
            ena_us  <= 1'b0;
         end
         strobes.us <= ena_us;  // registered copy

         // ms pulse lines up with the us pulse of the 1000th wrap
         strobes.ms <= ena_us && (us_cnt == rst_pkg::cnt_t'(999));

         if (ena_us)
         begin
            if (us_cnt == rst_pkg::cnt_t'(999))
               us_cnt <= '0;
            else
               us_cnt <= us_cnt + 1'b1;

            // systick, low first half, high second half
            if (st_cnt == rst_pkg::cnt_t'(systick_us - 1))
            begin
               st_cnt      <= '0;
               strobes.irq <= 1'b0;
            end
            else
            begin
               st_cnt <= st_cnt + 1'b1;
               if (st_cnt == rst_pkg::cnt_t'(systick_us / 2 - 1))
                  strobes.irq <= 1'b1;
            end
         end
      end
   end

endmodule : rst_timebase

`default_nettype wire

// File: src/rst_ctrl_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock and reset controller top level.
// Button and PLL conditioning feed the reset sequencer, whose sys_rst
// gates the timebase. All timing parameters are set here.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_top #(
   parameter int osc_per_ms  = 50000,  // osc_clk cycles per ms, button side
   parameter int debounce_ms = 10,
   parameter int longkey_ms  = 1000,
   parameter int pwr_width   = 7,
   parameter int dclo_width  = 15,
   parameter int aclo_delay  = 7,
   parameter int clk_per_us  = 50,
   parameter int systick_us  = 20000,
   parameter int slow_div    = 20
) (
   input  logic                osc_clk,
   input  logic                pwr_event,   // board power event, async
   input  logic                button_n,    // reset button, active low
   input  logic                pll_lock,
   input  logic                sys_ready,
   output rst_pkg::rst_lines_t lines,
   output rst_pkg::strobes_t   strobes
);

   rst_pkg::key_stat_t key;   // conditioner to sequencer

   rst_button_cond #(
      .osc_per_ms  (osc_per_ms),
      .debounce_ms (debounce_ms),
      .longkey_ms  (longkey_ms)
   ) u_button_cond (
      .osc_clk   (osc_clk),
      .pwr_event (pwr_event),
      .button_n  (button_n),
      .pll_lock  (pll_lock),
      .key       (key)
   );

   rst_sequencer #(
      .pwr_width  (pwr_width),
      .dclo_width (dclo_width),
      .aclo_delay (aclo_delay)
   ) u_sequencer (
      .osc_clk   (osc_clk),
      .pwr_event (pwr_event),
      .key       (key),
      .sys_ready (sys_ready),
      .lines     (lines)
   );

   // timebase only runs with the system out of warm reset
   rst_timebase #(
      .clk_per_us (clk_per_us),
      .systick_us (systick_us),
      .slow_div   (slow_div)
   ) u_timebase (
      .osc_clk   (osc_clk),
      .pwr_event (pwr_event),
      .sys_rst   (lines.sys_rst),
      .strobes   (strobes)
   );

endmodule : rst_ctrl_top

`default_nettype wire

// File: tb/tb_rst_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the clock and reset controller.
// Runs power-up order, ready gating, warm reset, long press, PLL loss
// and strobe timing against small parameters. Outputs sampled at negedge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_rst_ctrl;

   // small timing so the run stays short
   localparam int osc_per_ms  = 20;
   localparam int debounce_ms = 3;
   localparam int longkey_ms  = 20;
   localparam int pwr_width   = 7;
   localparam int dclo_width  = 15;
   localparam int aclo_delay  = 7;
   localparam int clk_per_us  = 4;
   localparam int systick_us  = 40;
   localparam int slow_div    = 5;

   // about 400 for the long press, 150 for pll loss and 8000 for two ms periods
   localparam int timeout_cycles = 30000;

   // release to sys_rst is 2 sync + debounce reg + sequencer plus up to 1 ms of tick phase
   localparam int warm_lo = debounce_ms * osc_per_ms + 4;
   localparam int warm_hi = warm_lo + osc_per_ms - 1;
   // press to pwr_rst covers sync, key_down, 20 ticks, key_long, pwr_req and lines
   localparam int long_lo = (longkey_ms - 1) * osc_per_ms + 6;
   localparam int long_hi = long_lo + osc_per_ms - 1;
   localparam int pll_lat = 4;           // 2 sync + pwr_req + lines

   // bit select into {strobes, lines}
   localparam int sel_aclo = 0;
   localparam int sel_dclo = 1;
   localparam int sel_sys  = 2;
   localparam int sel_pwr  = 3;
   localparam int sel_irq  = 4;
   localparam int sel_slow = 5;
   localparam int sel_ms   = 6;
   localparam int sel_us   = 7;

   logic                osc_clk;
   logic                pwr_event;
   logic                button_n;
   logic                pll_lock;
   logic                sys_ready;
   rst_pkg::rst_lines_t lines;
   rst_pkg::strobes_t   strobes;

   int   errors       = 0;
   int   cycles       = 0;
   int   leak_cycles  = 0;      // cycles with a strobe during a held sys_rst
   logic sys_rst_prev = 1'b1;

   rst_ctrl_top #(
      .osc_per_ms  (osc_per_ms),
      .debounce_ms (debounce_ms),
      .longkey_ms  (longkey_ms),
      .pwr_width   (pwr_width),
      .dclo_width  (dclo_width),
      .aclo_delay  (aclo_delay),
      .clk_per_us  (clk_per_us),
      .systick_us  (systick_us),
      .slow_div    (slow_div)
   ) u_rst_ctrl_top (
      .osc_clk   (osc_clk),
      .pwr_event (pwr_event),
      .button_n  (button_n),
      .pll_lock  (pll_lock),
      .sys_ready (sys_ready),
      .lines     (lines),
      .strobes   (strobes)
   );

   initial
   begin
      osc_clk = 1'b0;
      forever #4 osc_clk = ~osc_clk;   // 8 ns period
   end

   always @(posedge osc_clk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         errors++;
         $display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
         $display("error count %0d", errors);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // timebase clears one cycle after sys_rst is seen high
   always @(negedge osc_clk)
   begin
      if (sys_rst_prev && lines.sys_rst && strobes !== '0)
         leak_cycles++;
      sys_rst_prev = lines.sys_rst;
   end

   function automatic logic observed_bit(input int sel);
      logic [7:0] all;
      all = {strobes, lines};
      return all[sel];
   endfunction

   function automatic rst_pkg::rst_lines_t make_lines(input logic pwr, input logic sys,
                                                      input logic dclo, input logic aclo);
      return '{pwr_rst: pwr, sys_rst: sys, dclo: dclo, aclo: aclo};
   endfunction

   task automatic check_lines(input string name, input rst_pkg::rst_lines_t got,
                              input rst_pkg::rst_lines_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input rst_pkg::cnt_t got,
                              input rst_pkg::cnt_t lo, input rst_pkg::cnt_t hi);
      if (got < lo || got > hi)
      begin
         errors++;
         if (lo == hi)
            $display("CHECK FAILED %s got %h expected %h", name, got, lo);
         else
            $display("CHECK FAILED %s got %h expected %h to %h", name, got, lo, hi);
      end
   endtask

   // counts falling edges until the selected bit reaches level
   task automatic wait_level(input int sel, input logic level, input int limit,
                             input string name, output rst_pkg::cnt_t n);
      int k;
      k = 0;
      while (observed_bit(sel) !== level && k < limit)
      begin
         @(negedge osc_clk);
         k++;
      end
      if (observed_bit(sel) !== level)
      begin
         errors++;
         $display("%s never went %s within %0d cycles", name, level ? "high" : "low", limit);
      end
      n = rst_pkg::cnt_t'(k);
   endtask

   // distance between two single cycle pulses
   task automatic measure_gap(input int sel, input int limit, input string name,
                              output rst_pkg::cnt_t n);
      wait_level(sel, 1'b1, limit, name, n);
      @(negedge osc_clk);
      wait_level(sel, 1'b1, limit, name, n);
      n = n + 1'b1;
   endtask

   task automatic next_drive_slot();
      @(posedge osc_clk);
      #1;
   endtask

   // called on the negedge where sys_rst was first seen low
   task automatic release_tail(input string tag);
      rst_pkg::cnt_t n;
      wait_level(sel_dclo, 1'b0, dclo_width + 5, "dclo", n);
      check_count({tag, " dclo width"}, n, dclo_width, dclo_width);
      check_lines({tag, " lines after dclo"}, lines, make_lines(0, 0, 0, 1));
      wait_level(sel_aclo, 1'b0, aclo_delay + 5, "aclo", n);
      check_count({tag, " aclo delay"}, n, aclo_delay, aclo_delay);
      check_lines({tag, " lines after aclo"}, lines, make_lines(0, 0, 0, 0));
   endtask

   task automatic power_up_order();
      rst_pkg::cnt_t n;
      repeat (7) @(posedge osc_clk);
      @(negedge osc_clk);
      check_lines("lines in reset", lines, make_lines(1, 1, 1, 1));
      next_drive_slot();
      pwr_event = 1'b0;
      @(negedge osc_clk);
      wait_level(sel_pwr, 1'b0, 100, "pwr_rst", n);
      check_lines("lines after pwr_rst", lines, make_lines(0, 1, 1, 1));
      wait_level(sel_sys, 1'b0, 200, "sys_rst", n);
      check_lines("lines after sys_rst", lines, make_lines(0, 0, 1, 1));
      release_tail("power-up");
   endtask

   task automatic ready_gating();
      rst_pkg::cnt_t n;
      int            hold;
      logic          held_ok;
      hold    = 100 + ($urandom % 60);   // longer than the worst debounce
      held_ok = 1'b1;
      next_drive_slot();
      sys_ready = 1'b0;
      button_n  = 1'b0;
      @(negedge osc_clk);
      wait_level(sel_sys, 1'b1, 20, "sys_rst", n);
      check_lines("lines on press", lines, make_lines(0, 1, 1, 1));
      repeat (10) next_drive_slot();
      button_n = 1'b1;
      repeat (hold)
      begin
         @(negedge osc_clk);
         if (held_ok && lines !== make_lines(0, 1, 1, 1))
         begin
            check_lines("lines while not ready", lines, make_lines(0, 1, 1, 1));
            held_ok = 1'b0;
         end
      end
      next_drive_slot();
      sys_ready = 1'b1;
      @(negedge osc_clk);
      wait_level(sel_sys, 1'b0, 10, "sys_rst", n);
      check_count("sys_ready to sys_rst", n, 1, 1);
      release_tail("ready gating");
   endtask

   task automatic warm_reset();
      rst_pkg::cnt_t n;
      int            press_len;
      press_len = 10 + ($urandom % 100);  // well short of a long press
      next_drive_slot();
      button_n = 1'b0;
      @(negedge osc_clk);
      wait_level(sel_sys, 1'b1, 20, "sys_rst", n);
      check_lines("lines on warm press", lines, make_lines(0, 1, 1, 1));
      repeat (press_len) next_drive_slot();
      button_n = 1'b1;
      @(negedge osc_clk);
      wait_level(sel_sys, 1'b0, warm_hi + 10, "sys_rst", n);
      check_count("release to sys_rst", n, warm_lo, warm_hi);
      release_tail("warm reset");
   endtask

   task automatic long_press_reset();
      rst_pkg::cnt_t n;
      next_drive_slot();
      button_n = 1'b0;
      @(negedge osc_clk);
      wait_level(sel_pwr, 1'b1, long_hi + 20, "pwr_rst", n);
      check_count("press to pwr_rst", n, long_lo, long_hi);
      check_lines("lines on long press", lines, make_lines(1, 1, 1, 1));
      next_drive_slot();
      button_n = 1'b1;
      @(negedge osc_clk);
      wait_level(sel_pwr, 1'b0, 200, "pwr_rst", n);
      check_lines("lines after long press", lines, make_lines(0, 1, 1, 1));
      wait_level(sel_sys, 1'b0, 10, "sys_rst", n);
      check_count("pwr_rst to sys_rst", n, 1, 1);  // key_down already low
      release_tail("long press");
   endtask

   task automatic pll_loss_reset();
      rst_pkg::cnt_t n;
      next_drive_slot();
      pll_lock = 1'b0;
      @(negedge osc_clk);
      wait_level(sel_pwr, 1'b1, 20, "pwr_rst", n);
      check_count("pll loss to pwr_rst", n, pll_lat, pll_lat);
      check_lines("lines on pll loss", lines, make_lines(1, 1, 1, 1));
      repeat (20) next_drive_slot();
      pll_lock = 1'b1;
      @(negedge osc_clk);
      wait_level(sel_pwr, 1'b0, 100, "pwr_rst", n);
      check_lines("lines after pll relock", lines, make_lines(0, 1, 1, 1));
      wait_level(sel_sys, 1'b0, 200, "sys_rst", n);
      release_tail("pll loss");
   endtask

   task automatic strobe_timing();
      rst_pkg::cnt_t n;
      measure_gap(sel_us, 20, "us strobe", n);
      check_count("us gap", n, clk_per_us, clk_per_us);
      measure_gap(sel_slow, 20, "slow strobe", n);
      check_count("slow gap", n, slow_div, slow_div);
      wait_level(sel_irq, 1'b0, systick_us * clk_per_us, "irq", n);
      wait_level(sel_irq, 1'b1, systick_us * clk_per_us, "irq", n);
      wait_level(sel_irq, 1'b0, systick_us * clk_per_us, "irq", n);
      check_count("irq high time", n, systick_us / 2 * clk_per_us, systick_us / 2 * clk_per_us);
      wait_level(sel_irq, 1'b1, systick_us * clk_per_us, "irq", n);
      check_count("irq low time", n, systick_us / 2 * clk_per_us, systick_us / 2 * clk_per_us);
      measure_gap(sel_ms, 1000 * clk_per_us + 20, "ms strobe", n);
      check_count("ms gap", n, 1000 * clk_per_us, 1000 * clk_per_us);
      check_count("strobes while sys_rst held", rst_pkg::cnt_t'(leak_cycles), 0, 0);
   endtask

   initial
   begin
      pwr_event = 1'b1;        // power reset from time zero
      button_n  = 1'b1;
      pll_lock  = 1'b1;
      sys_ready = 1'b1;
      void'($urandom(91));     // fixed seed for press and hold lengths

      power_up_order();
      ready_gating();
      warm_reset();
      long_press_reset();
      pll_loss_reset();
      strobe_timing();

      $display("error count %0d", errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule : tb_rst_ctrl

`default_nettype wire

// File: flist.f
src/rst_pkg.sv
src/rst_button_cond.sv
src/rst_sequencer.sv
src/rst_timebase.sv
src/rst_ctrl_top.sv
tb/tb_rst_ctrl.sv
